/* Bender.yml */
package:
  name: ic_subsys

sources:
  - files:
      - hdl/ic_cache_pkg.sv
      - hdl/ic_bus_pkg.sv
      - hdl/ic_fill_ctrl.sv
      - hdl/ic_l1_array.sv
      - hdl/ic_l2_store.sv
      - hdl/ic_subsys.sv
  - target: test
    files:
      - testbench/tb_ic_subsys.sv

/* files.f */
hdl/ic_cache_pkg.sv
hdl/ic_bus_pkg.sv
hdl/ic_fill_ctrl.sv
hdl/ic_l1_array.sv
hdl/ic_l2_store.sv
hdl/ic_subsys.sv
testbench/tb_ic_subsys.sv

/* hdl/ic_bus_pkg.sv */
package ic_bus_pkg;

	// ========================================================================
	// Wishbone-style burst bus
	// ========================================================================

	// Width of one data beat
	localparam int BEAT_BITS = 128;

	// Cycle type identifier
	// Classic when idle, incrementing burst, end of burst on the last beat
	typedef enum logic [2:0] {
		CTI_CLASSIC = 3'd0,
		CTI_INCR    = 3'd1,
		CTI_END     = 3'd7
	} bus_cti_e;

	// Master side of the bus
	typedef struct packed {
		logic                       cyc;
		logic                       stb;
		// Instruction cache line load
		logic                       icl;
		bus_cti_e                   cti;
		logic [1:0]                 bte;
		logic [15:0]                sel;
		logic [ic_cache_pkg::AW-1:0] adr;
	} bus_req_t;

	// Slave side of the bus
	// Any of ack, err, tlbmiss or exv terminates a beat
	typedef struct packed {
		logic                   ack;
		logic                   err;
		logic                   tlbmiss;
		logic                   exv;
		logic [BEAT_BITS-1:0]   dat;
	} bus_rsp_t;

endpackage

/* hdl/ic_cache_pkg.sv */
package ic_cache_pkg;

	// ========================================================================
	// Cache geometry
	// ========================================================================

	// Fetch address width, one machine word
	localparam int AW = 32;

	// A line holds two 128-bit bus beats
	localparam int LINE_BITS = 256;

	// Byte offset bits inside a line and inside one beat
	localparam int LINE_OFS = 5;
	localparam int BEAT_OFS = 4;

	// ========================================================================
	// Line format
	// ========================================================================

	// Fault code stored alongside each line
	typedef enum logic [1:0] {
		FLT_NONE = 2'd0,
		FLT_TLB  = 2'd1,
		FLT_EXV  = 2'd2,
		FLT_ERR  = 2'd3
	} ic_fault_e;

	// Fault code sits above the data, 258 bits in all
	typedef struct packed {
		ic_fault_e              flt;
		logic [LINE_BITS-1:0]   dat;
	} ic_line_t;

	// No-operation bundle, repeated twice to fill a faulted line
	localparam logic [127:0] NOP_WORD = {8'h1f, 120'h0};

	// ========================================================================
	// Refill controller states
	// ========================================================================

	typedef enum logic [2:0] {
		IDLE      = 3'd0,
		L2_WAIT   = 3'd1,
		L2_PROBE  = 3'd2,
		BUS_ACK   = 3'd3,
		BUS_GAP   = 3'd4,
		FILL_DONE = 3'd5,
		WR_WAIT   = 3'd6
	} ic_state_e;

endpackage

/* hdl/ic_fill_ctrl.sv */
`timescale 1ns/1ps

module ic_fill_ctrl #(
	parameter int AW        = ic_cache_pkg::AW,
	parameter int L2_RD_LAT = 3,
	parameter int L1_WR_LAT = 3
) (
	input  logic                   clk,
	input  logic                   rst_i,
	input  logic [AW-1:0]          ip_i,
	input  logic                   l1_hit_i,
	input  logic                   inv_i,
	input  logic [AW-1:0]          inv_adr_i,
	input  logic                   l2_hit_i,
	input  ic_cache_pkg::ic_line_t l2_line_i,
	input  logic                   bus_gnt_i,
	input  logic                   bok_i,
	input  ic_bus_pkg::bus_rsp_t   bus_rsp_i,
	output ic_bus_pkg::bus_req_t   bus_req_o,
	output logic [AW-1:0]          l1_adr_o,
	output ic_cache_pkg::ic_line_t l1_line_o,
	output logic                   l1_wr_o,
	output logic                   l1_inv_o,
	output logic [AW-1:0]          l2_adr_o,
	output logic                   l2_ld_o,
	output logic                   l2_beat_o,
	output logic [31:0]            fill_cnt_o
);

	localparam int LO = ic_cache_pkg::LINE_OFS;
	localparam int BO = ic_cache_pkg::BEAT_OFS;

	ic_cache_pkg::ic_state_e state_q;
	// Previous state, tells the first L2_PROBE cycle apart
	ic_cache_pkg::ic_state_e prev_q;
	logic [7:0]              cnt_q;
	logic                    beat_q;
	ic_bus_pkg::bus_req_t    req_q;
	logic [AW-1:0]           l1_adr_q;
	logic [AW-1:0]           l2_adr_q;
	ic_cache_pkg::ic_line_t  l1_line_q;
	logic                    l1_wr_q;
	logic                    l1_inv_q;
	logic                    l2_ld_q;
	logic                    inv_pend_q;
	logic [AW-1:0]           inv_adr_q;
	logic [31:0]             fill_cnt_q;

	// Beat termination and fault flags
	logic rsp_any;
	logic flt_any;

	// Clear the byte offset to get the line address
	function automatic logic [AW-1:0] line_base(input logic [AW-1:0] adr);
		return {adr[AW-1:LO], {LO{1'b0}}};
	endfunction

	// Fault line, NOP bundles tagged with the fault code
	function automatic ic_cache_pkg::ic_line_t fault_line(input ic_cache_pkg::ic_fault_e code);
		ic_cache_pkg::ic_line_t l;
		l.flt = code;
		l.dat = {2{ic_cache_pkg::NOP_WORD}};
		return l;
	endfunction

	assign rsp_any = bus_rsp_i.ack | bus_rsp_i.err | bus_rsp_i.tlbmiss | bus_rsp_i.exv;
	assign flt_any = bus_rsp_i.err | bus_rsp_i.tlbmiss | bus_rsp_i.exv;

	// ========================================================================
	// Refill state machine
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q    <= ic_cache_pkg::IDLE;
			prev_q     <= ic_cache_pkg::IDLE;
			cnt_q      <= '0;
			beat_q     <= 1'b0;
			req_q      <= '0;
			l1_wr_q    <= 1'b0;
			l1_inv_q   <= 1'b0;
			l2_ld_q    <= 1'b0;
			inv_pend_q <= 1'b0;
			fill_cnt_q <= '0;
		end else begin
			// Write and invalidate are single-cycle pulses
			l1_wr_q  <= 1'b0;
			l1_inv_q <= 1'b0;
			prev_q   <= state_q;
			case (state_q)
			ic_cache_pkg::IDLE: begin
				cnt_q <= '0;
				// Pending invalidate goes ahead of any miss
				if (inv_pend_q) begin
					l1_adr_q   <= line_base(inv_adr_q);
					l1_inv_q   <= 1'b1;
					inv_pend_q <= 1'b0;
				end else if (!l1_hit_i) begin
					l1_adr_q <= line_base(ip_i);
					l2_adr_q <= line_base(ip_i);
					state_q  <= ic_cache_pkg::L2_WAIT;
				end
			end
			// Let the L2 read settle, L2_RD_LAT+1 cycles
			ic_cache_pkg::L2_WAIT: begin
				cnt_q <= cnt_q + 8'd1;
				if (cnt_q == 8'(L2_RD_LAT)) begin
					cnt_q   <= '0;
					state_q <= ic_cache_pkg::L2_PROBE;
				end
			end
			// Hit only counts on the first probe cycle
			// a later hit would come from our own bus fill
			ic_cache_pkg::L2_PROBE: begin
				if (l2_hit_i && prev_q == ic_cache_pkg::L2_WAIT) begin
					l1_line_q <= l2_line_i;
					l1_wr_q   <= 1'b1;
					cnt_q     <= '0;
					state_q   <= ic_cache_pkg::WR_WAIT;
				end else if (bus_gnt_i) begin
					req_q.cyc <= 1'b1;
					req_q.stb <= 1'b1;
					req_q.icl <= 1'b1;
					req_q.cti <= ic_bus_pkg::CTI_INCR;
					req_q.bte <= 2'b00;
					req_q.sel <= 16'hffff;
					req_q.adr <= l1_adr_q;
					beat_q    <= 1'b0;
					l2_ld_q   <= 1'b1;
					state_q   <= ic_cache_pkg::BUS_ACK;
				end
			end
			ic_cache_pkg::BUS_ACK: begin
				if (rsp_any) begin
					// Fault priority is tlb miss, then execute violation, then error
					if (bus_rsp_i.tlbmiss) begin
						l1_line_q <= fault_line(ic_cache_pkg::FLT_TLB);
					end else if (bus_rsp_i.exv) begin
						l1_line_q <= fault_line(ic_cache_pkg::FLT_EXV);
					end else if (bus_rsp_i.err) begin
						l1_line_q <= fault_line(ic_cache_pkg::FLT_ERR);
					end else if (!beat_q) begin
						l1_line_q.dat[127:0] <= bus_rsp_i.dat;
						l1_line_q.flt        <= ic_cache_pkg::FLT_NONE;
					end else begin
						l1_line_q.dat[255:128] <= bus_rsp_i.dat;
						l1_line_q.flt          <= ic_cache_pkg::FLT_NONE;
					end
					beat_q <= 1'b1;
					// Last beat or a fault closes the cycle
					if (flt_any || beat_q) begin
						req_q.cyc <= 1'b0;
						req_q.stb <= 1'b0;
						req_q.icl <= 1'b0;
						req_q.cti <= ic_bus_pkg::CTI_CLASSIC;
						req_q.sel <= 16'h0000;
						l2_ld_q   <= 1'b0;
						state_q   <= ic_cache_pkg::FILL_DONE;
					end else begin
						req_q.cti <= ic_bus_pkg::CTI_END;
						// No burst allowed, drop stb and step to the next beat
						if (!bok_i) begin
							req_q.stb         <= 1'b0;
							req_q.adr[AW-1:BO] <= req_q.adr[AW-1:BO] + 1'b1;
							state_q           <= ic_cache_pkg::BUS_GAP;
						end
					end
				end
			end
			// Wait for the slave to release ack before the next strobe
			ic_cache_pkg::BUS_GAP: begin
				if (!bus_rsp_i.ack) begin
					req_q.stb <= 1'b1;
					state_q   <= ic_cache_pkg::BUS_ACK;
				end
			end
			ic_cache_pkg::FILL_DONE: begin
				l1_wr_q    <= 1'b1;
				fill_cnt_q <= fill_cnt_q + 32'd1;
				cnt_q      <= '0;
				state_q    <= ic_cache_pkg::WR_WAIT;
			end
			// L1 write must land before fetch resumes
			ic_cache_pkg::WR_WAIT: begin
				cnt_q <= cnt_q + 8'd1;
				if (cnt_q == 8'(L1_WR_LAT)) begin
					state_q <= ic_cache_pkg::IDLE;
				end
			end
			default: state_q <= ic_cache_pkg::IDLE;
			endcase
			// Latch last, a new request is never lost to the IDLE clear
			if (inv_i) begin
				inv_pend_q <= 1'b1;
				inv_adr_q  <= inv_adr_i;
			end
		end
	end

	assign bus_req_o  = req_q;
	assign l1_adr_o   = l1_adr_q;
	assign l1_line_o  = l1_line_q;
	assign l1_wr_o    = l1_wr_q;
	assign l1_inv_o   = l1_inv_q;
	assign l2_adr_o   = l2_adr_q;
	// L2 captures only clean beats of the fill in progress
	assign l2_ld_o    = l2_ld_q && state_q == ic_cache_pkg::BUS_ACK &&
	                    bus_rsp_i.ack && !flt_any;
	assign l2_beat_o  = beat_q;
	assign fill_cnt_o = fill_cnt_q;

	// ========================================================================
	// Assertions
	// ========================================================================

	// No bus cycle may outlive a refill
	a_idle_no_cyc: assert property (@(posedge clk) disable iff (rst_i)
		state_q == ic_cache_pkg::IDLE |-> !bus_req_o.cyc);

	// L1 sees a single address port, write and invalidate share it
	a_wr_inv_excl: assert property (@(posedge clk) disable iff (rst_i)
		!(l1_wr_o && l1_inv_o));

	a_stb_cyc: assert property (@(posedge clk) disable iff (rst_i)
		bus_req_o.stb |-> bus_req_o.cyc);

endmodule

/* hdl/ic_l1_array.sv */
`timescale 1ns/1ps

module ic_l1_array #(
	parameter int AW       = ic_cache_pkg::AW,
	parameter int L1_LINES = 16
) (
	input  logic                   clk,
	input  logic                   rst_i,
	input  logic [AW-1:0]          rd_adr_i,
	output logic                   hit_o,
	output ic_cache_pkg::ic_line_t line_o,
	input  logic [AW-1:0]          wr_adr_i,
	input  logic                   wr_i,
	input  logic                   inv_i,
	input  ic_cache_pkg::ic_line_t wr_line_i
);

	// ========================================================================
	// Direct-mapped geometry
	// ========================================================================

	localparam int IDX_W = $clog2(L1_LINES);
	localparam int TAG_W = AW - ic_cache_pkg::LINE_OFS - IDX_W;

	// Valid bits need reset, tags and lines do not
	logic [L1_LINES-1:0]    valid_q;
	logic [TAG_W-1:0]       tag_mem  [L1_LINES];
	ic_cache_pkg::ic_line_t line_mem [L1_LINES];

	logic [IDX_W-1:0] rd_idx;
	logic [TAG_W-1:0] rd_tag;
	logic [IDX_W-1:0] wr_idx;
	logic [TAG_W-1:0] wr_tag;

	// Index sits just above the line offset, tag takes the rest
	assign rd_idx = rd_adr_i[ic_cache_pkg::LINE_OFS +: IDX_W];
	assign rd_tag = rd_adr_i[AW-1 -: TAG_W];
	assign wr_idx = wr_adr_i[ic_cache_pkg::LINE_OFS +: IDX_W];
	assign wr_tag = wr_adr_i[AW-1 -: TAG_W];

	// ========================================================================
	// Read port, combinational for the fetch address
	// ========================================================================

	assign hit_o  = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);
	assign line_o = line_mem[rd_idx];

	// ========================================================================
	// Write and invalidate
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_q <= '0;
		end else if (wr_i) begin
			valid_q[wr_idx] <= 1'b1;
		end else if (inv_i && tag_mem[wr_idx] == wr_tag) begin
			// only drop the line if it still belongs to that address
			valid_q[wr_idx] <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_i) begin
			tag_mem[wr_idx]  <= wr_tag;
			line_mem[wr_idx] <= wr_line_i;
		end
	end

	// Controller must never write and invalidate on the same cycle
	a_wr_inv: assert property (@(posedge clk) disable iff (rst_i)
		!(wr_i && inv_i));

endmodule

/* hdl/ic_l2_store.sv */
`timescale 1ns/1ps

module ic_l2_store #(
	parameter int AW       = ic_cache_pkg::AW,
	parameter int L2_LINES = 64
) (
	input  logic                              clk,
	input  logic                              rst_i,
	input  logic [AW-1:0]                     adr_i,
	input  logic                              ld_i,
	input  logic                              beat_i,
	input  logic [ic_bus_pkg::BEAT_BITS-1:0]  beat_dat_i,
	output logic                              hit_o,
	output ic_cache_pkg::ic_line_t            line_o
);

	// ========================================================================
	// Direct-mapped geometry
	// ========================================================================

	localparam int IDX_W = $clog2(L2_LINES);
	localparam int TAG_W = AW - ic_cache_pkg::LINE_OFS - IDX_W;

	logic [L2_LINES-1:0]                        valid_q;
	logic [TAG_W-1:0]                           tag_mem [L2_LINES];
	// Two beat halves per line, low half first
	logic [1:0][ic_bus_pkg::BEAT_BITS-1:0]      dat_mem [L2_LINES];

	logic [IDX_W-1:0] idx;
	logic [TAG_W-1:0] tag;

	// Registered probe result
	logic                   hit_q;
	ic_cache_pkg::ic_line_t line_q;

	assign idx = adr_i[ic_cache_pkg::LINE_OFS +: IDX_W];
	assign tag = adr_i[AW-1 -: TAG_W];

	// ========================================================================
	// Beat loading
	// ========================================================================

	// Beat 0 drops the old line, beat 1 completes the new one
	// A faulting beat never arrives here, so the line stays invalid
	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_q <= '0;
		end else if (ld_i) begin
			valid_q[idx] <= beat_i;
		end
	end

	always_ff @(posedge clk) begin
		if (ld_i) begin
			tag_mem[idx]         <= tag;
			dat_mem[idx][beat_i] <= beat_dat_i;
		end
	end

	// ========================================================================
	// Probe
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst_i) begin
			hit_q <= 1'b0;
		end else begin
			hit_q <= valid_q[idx] && (tag_mem[idx] == tag);
		end
	end

	// L2 only ever holds clean lines
	always_ff @(posedge clk) begin
		line_q.flt <= ic_cache_pkg::FLT_NONE;
		line_q.dat <= dat_mem[idx];
	end

	assign hit_o  = hit_q;
	assign line_o = line_q;

endmodule

/* hdl/ic_subsys.sv */
`timescale 1ns/1ps

module ic_subsys #(
	parameter int AW        = ic_cache_pkg::AW,
	parameter int L1_LINES  = 16,
	parameter int L2_LINES  = 64,
	parameter int L2_RD_LAT = 3,
	parameter int L1_WR_LAT = 3
) (
	input  logic                   clk,
	input  logic                   rst_i,
	// Fetch side
	input  logic [AW-1:0]          ip_i,
	output logic                   hit_o,
	output ic_cache_pkg::ic_line_t line_o,
	input  logic                   inv_i,
	input  logic [AW-1:0]          inv_adr_i,
	// Bus side
	input  logic                   bus_gnt_i,
	input  logic                   bok_i,
	input  ic_bus_pkg::bus_rsp_t   bus_rsp_i,
	output ic_bus_pkg::bus_req_t   bus_req_o,
	output logic [31:0]            fill_cnt_o
);

	// Controller to L1
	logic [AW-1:0]          l1_adr;
	ic_cache_pkg::ic_line_t l1_line;
	logic                   l1_wr;
	logic                   l1_inv;

	// Controller to and from L2
	logic [AW-1:0]          l2_adr;
	logic                   l2_ld;
	logic                   l2_beat;
	logic                   l2_hit;
	ic_cache_pkg::ic_line_t l2_line;

	// ========================================================================
	// Refill controller
	// ========================================================================

	ic_fill_ctrl #(
		.AW        (AW),
		.L2_RD_LAT (L2_RD_LAT),
		.L1_WR_LAT (L1_WR_LAT)
	) u_ctrl (
		.clk        (clk),
		.rst_i      (rst_i),
		.ip_i       (ip_i),
		.l1_hit_i   (hit_o),
		.inv_i      (inv_i),
		.inv_adr_i  (inv_adr_i),
		.l2_hit_i   (l2_hit),
		.l2_line_i  (l2_line),
		.bus_gnt_i  (bus_gnt_i),
		.bok_i      (bok_i),
		.bus_rsp_i  (bus_rsp_i),
		.bus_req_o  (bus_req_o),
		.l1_adr_o   (l1_adr),
		.l1_line_o  (l1_line),
		.l1_wr_o    (l1_wr),
		.l1_inv_o   (l1_inv),
		.l2_adr_o   (l2_adr),
		.l2_ld_o    (l2_ld),
		.l2_beat_o  (l2_beat),
		.fill_cnt_o (fill_cnt_o)
	);

	// ========================================================================
	// L1 array, read port faces the fetch address
	// ========================================================================

	ic_l1_array #(
		.AW       (AW),
		.L1_LINES (L1_LINES)
	) u_l1 (
		.clk       (clk),
		.rst_i     (rst_i),
		.rd_adr_i  (ip_i),
		.hit_o     (hit_o),
		.line_o    (line_o),
		.wr_adr_i  (l1_adr),
		.wr_i      (l1_wr),
		.inv_i     (l1_inv),
		.wr_line_i (l1_line)
	);

	// L2 loads straight from the bus data
	ic_l2_store #(
		.AW       (AW),
		.L2_LINES (L2_LINES)
	) u_l2 (
		.clk        (clk),
		.rst_i      (rst_i),
		.adr_i      (l2_adr),
		.ld_i       (l2_ld),
		.beat_i     (l2_beat),
		.beat_dat_i (bus_rsp_i.dat),
		.hit_o      (l2_hit),
		.line_o     (l2_line)
	);

endmodule

/* testbench/ic_testdata.txt */
# op adr flt bok l2hit
# op F fetch or I invalidate, adr hex, flt 0 none 1 tlb 2 exv 3 err, l2hit 1 if served by L2
F 00001000 0 1 0
F 00001020 0 1 0
F 00001040 0 0 0
F 00001060 0 0 0
I 00001000 0 1 0
F 00001000 0 1 1
I 00001040 0 0 0
F 00001040 0 0 1
F 00002080 1 1 0
F 000020a0 2 1 0
F 000020c0 3 0 0
I 00002080 0 1 0
F 00002080 1 1 0
F 000010e0 0 1 0
F 00001100 0 0 0
F 00001120 0 1 0
F 00001300 0 1 0
F 00001100 0 1 1
F 00001300 0 0 1
F 00003140 0 0 0
F 00003164 0 1 0
F 00003180 0 0 0
F 000031a0 0 1 0
F 000031c0 3 1 0
F 000031ec 0 0 0
I 000031a0 0 1 0
F 000031a0 0 1 1
I 00001020 0 0 0
F 00001020 0 0 1

/* testbench/tb_ic_subsys.sv */
`timescale 1ns/1ps

module tb_ic_subsys;

	localparam int AW        = ic_cache_pkg::AW;
	localparam int LO        = ic_cache_pkg::LINE_OFS;
	localparam int OP_CYCLES = 64;

	logic                   clk;
	logic                   rst_i;
	logic [AW-1:0]          ip_i;
	logic                   hit_o;
	ic_cache_pkg::ic_line_t line_o;
	logic                   inv_i;
	logic [AW-1:0]          inv_adr_i;
	logic                   bus_gnt_i;
	logic                   bok_i;
	ic_bus_pkg::bus_rsp_t   bus_rsp_i;
	ic_bus_pkg::bus_req_t   bus_req_o;
	logic [31:0]            fill_cnt_o;

	// Operation list from the data file
	byte                     op_q  [$];
	logic [AW-1:0]           adr_q [$];
	ic_cache_pkg::ic_fault_e flt_q [$];
	logic                    bok_q [$];
	logic                    l2_q  [$];
	int                      n_ops;

	// Line the bus model is expected to serve
	logic [AW-1:0]           cur_line;
	ic_cache_pkg::ic_fault_e cur_flt;
	logic                    cur_bok;
	// Lines served by the bus model so far
	logic [31:0]             line_cnt;
	// Counts at the start of the current fetch
	logic [31:0]             base_fill;
	logic [31:0]             base_lines;
	logic [31:0]             lfsr_q;
	int                      cycle_cnt;
	int                      limit;

	ic_subsys #(
		.AW        (AW),
		.L1_LINES  (16),
		.L2_LINES  (64),
		.L2_RD_LAT (3),
		.L1_WR_LAT (3)
	) dut (
		.clk        (clk),
		.rst_i      (rst_i),
		.ip_i       (ip_i),
		.hit_o      (hit_o),
		.line_o     (line_o),
		.inv_i      (inv_i),
		.inv_adr_i  (inv_adr_i),
		.bus_gnt_i  (bus_gnt_i),
		.bok_i      (bok_i),
		.bus_rsp_i  (bus_rsp_i),
		.bus_req_o  (bus_req_o),
		.fill_cnt_o (fill_cnt_o)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// ========================================================================
	// Error reporting and compare tasks
	// ========================================================================

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_line(input string what, input ic_cache_pkg::ic_line_t got,
	                          input ic_cache_pkg::ic_line_t want);
		if (got !== want) begin
			report_failure($sformatf("Fail at %0t: %s, got %0d/%h, expected %0d/%h",
				$time, what, got.flt, got.dat, want.flt, want.dat));
		end
	endtask

	task automatic check_count(input string what, input logic [31:0] got,
	                           input logic [31:0] want);
		if (got !== want) begin
			report_failure($sformatf("Fail at %0t: %s, got %0d, expected %0d",
				$time, what, got, want));
		end
	endtask

	task automatic check_req(input string what, input ic_bus_pkg::bus_req_t got,
	                         input ic_bus_pkg::bus_req_t want);
		if (got !== want) begin
			report_failure($sformatf("Fail at %0t: %s, got %h, expected %h",
				$time, what, got, want));
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic want);
		if (got !== want) begin
			report_failure($sformatf("Fail at %0t: %s, got %b, expected %b",
				$time, what, got, want));
		end
	endtask

	// ========================================================================
	// Random source and memory rule
	// ========================================================================

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit taken
	task automatic rand_bits(input int n, output logic [7:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v      = {v[6:0], lfsr_q[0]};
		end
	endtask

	// Every word is its byte address XOR 5a5a0000
	function automatic logic [127:0] mem_beat(input logic [AW-1:0] adr);
		logic [127:0] d;
		for (int w = 0; w < 4; w++) begin
			d[32*w +: 32] = (adr + 32'(4 * w)) ^ 32'h5a5a0000;
		end
		return d;
	endfunction

	// ========================================================================
	// Bus model
	// ========================================================================

	// Grant toggles in runs of 1 to 8 cycles
	initial begin : gnt_gen
		logic [7:0] lvl;
		logic [7:0] len;
		int         hold;
		bus_gnt_i = 1'b0;
		hold      = 0;
		forever begin
			@(posedge clk);
			#1;
			if (hold == 0) begin
				rand_bits(1, lvl);
				rand_bits(3, len);
				bus_gnt_i = lvl[0];
				hold      = len + 1;
			end
			hold = hold - 1;
		end
	end

	task automatic serve_line();
		ic_bus_pkg::bus_req_t want;
		logic [7:0]           dly;
		logic [AW-1:0]        badr;
		logic                 stop;
		stop     = 1'b0;
		line_cnt = line_cnt + 1;
		for (int b = 0; b < 2 && !stop; b++) begin
			// Gap mode, stb returns once ack is low
			while (!bus_req_o.stb) begin
				@(posedge clk);
				#1;
			end
			badr     = cur_line + 32'(16 * b);
			want     = '0;
			want.cyc = 1'b1;
			want.stb = 1'b1;
			want.icl = 1'b1;
			want.sel = 16'hffff;
			if (b == 0) begin
				want.cti = ic_bus_pkg::CTI_INCR;
				want.adr = cur_line;
			end else begin
				want.cti = ic_bus_pkg::CTI_END;
				// Burst keeps the line address, gap mode steps it
				want.adr = cur_bok ? cur_line : badr;
			end
			check_req("bus request", bus_req_o, want);
			// Late response, 0 to 3 cycles
			rand_bits(2, dly);
			repeat (dly) begin
				@(posedge clk);
				#1;
				check_req("held bus request", bus_req_o, want);
			end
			if (b == 0 && cur_flt != ic_cache_pkg::FLT_NONE) begin
				case (cur_flt)
				ic_cache_pkg::FLT_TLB: bus_rsp_i.tlbmiss = 1'b1;
				ic_cache_pkg::FLT_EXV: bus_rsp_i.exv = 1'b1;
				default:               bus_rsp_i.err = 1'b1;
				endcase
				stop = 1'b1;
			end else begin
				bus_rsp_i.ack = 1'b1;
				bus_rsp_i.dat = mem_beat(badr);
			end
			@(posedge clk);
			#1;
			bus_rsp_i = '0;
		end
	endtask

	initial begin : bus_slave
		bus_rsp_i = '0;
		line_cnt  = '0;
		forever begin
			@(posedge clk);
			#1;
			if (!rst_i && bus_req_o.cyc) begin
				serve_line();
			end
		end
	end

	// ========================================================================
	// Stimulus
	// ========================================================================

	task automatic load_ops();
		int            fd;
		int            n;
		string         text;
		byte           op;
		logic [AW-1:0] adr;
		int            flt;
		int            bok;
		int            l2;
		n_ops = 0;
		fd    = $fopen("testbench/ic_testdata.txt", "r");
		if (fd == 0) begin
			report_failure("Could not open the stimulus file testbench/ic_testdata.txt");
		end else begin
			while ($fgets(text, fd) > 0) begin
				// Hash lines describe the columns
				if (text.len() > 1 && text.getc(0) != "#") begin
					n = $sscanf(text, "%c %h %d %d %d", op, adr, flt, bok, l2);
					if (n != 5 || (op != "F" && op != "I")) begin
						report_failure({"Malformed line in the stimulus file: ", text});
					end
					op_q.push_back(op);
					adr_q.push_back(adr);
					flt_q.push_back(ic_cache_pkg::ic_fault_e'(flt[1:0]));
					bok_q.push_back(bok[0]);
					l2_q.push_back(l2[0]);
					n_ops++;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_fetch(input logic [AW-1:0] adr, input ic_cache_pkg::ic_fault_e flt,
	                         input logic bok, input logic l2_hit);
		ic_cache_pkg::ic_line_t want;
		logic [AW-1:0]          base;
		base     = {adr[AW-1:LO], {LO{1'b0}}};
		cur_line = base;
		cur_flt  = flt;
		cur_bok  = bok;
		@(posedge clk);
		#1;
		ip_i  = adr;
		bok_i = bok;
		@(posedge clk);
		#1;
		check_flag("L1 hit at fetch start", hit_o, 1'b0);
		while (!hit_o) begin
			@(posedge clk);
			#1;
		end
		want.flt = flt;
		if (flt != ic_cache_pkg::FLT_NONE) begin
			want.dat = {2{ic_cache_pkg::NOP_WORD}};
		end else begin
			want.dat = {mem_beat(base + 32'd16), mem_beat(base)};
		end
		check_line("fetched line", line_o, want);
		// L2 refills leave both the bus and the counter alone
		if (l2_hit) begin
			check_count("fill count", fill_cnt_o, base_fill);
			check_count("bus line count", line_cnt, base_lines);
		end else begin
			check_count("fill count", fill_cnt_o, base_fill + 32'd1);
			check_count("bus line count", line_cnt, base_lines + 32'd1);
		end
	endtask

	task automatic run_inval(input logic [AW-1:0] adr);
		@(posedge clk);
		#1;
		ip_i      = adr;
		inv_adr_i = adr;
		inv_i     = 1'b1;
		@(posedge clk);
		#1;
		inv_i = 1'b0;
		check_flag("L1 hit before invalidate", hit_o, 1'b1);
		// Line drops, then the refetch starts on its own
		while (hit_o) begin
			@(posedge clk);
			#1;
		end
	endtask

	// Run limit scales with the operation count
	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (limit > 0 && cycle_cnt >= limit) begin
			report_failure($sformatf("Timeout after %0d cycles, operations did not complete",
				cycle_cnt));
		end
	end

	initial begin : main
		rst_i      = 1'b1;
		ip_i       = '0;
		inv_i      = 1'b0;
		inv_adr_i  = '0;
		bok_i      = 1'b1;
		cur_line   = '0;
		cur_flt    = ic_cache_pkg::FLT_NONE;
		cur_bok    = 1'b1;
		base_fill  = '0;
		base_lines = '0;
		lfsr_q     = 32'h3fc0895f;
		cycle_cnt  = 0;
		limit      = 0;
		load_ops();
		limit = n_ops * OP_CYCLES;
		// Any fetch address misses once reset lifts
		// so the port already holds the first one
		if (n_ops > 0) begin
			ip_i = adr_q[0];
		end
		repeat (4) @(posedge clk);
		#1;
		rst_i = 1'b0;
		check_req("bus request after reset", bus_req_o, '0);
		check_count("fill count after reset", fill_cnt_o, 32'd0);
		check_flag("L1 hit after reset", hit_o, 1'b0);
		for (int i = 0; i < n_ops; i++) begin
			// Refetch after an invalidate counts toward the next fetch
			if (i == 0 || op_q[i-1] != "I") begin
				base_fill  = fill_cnt_o;
				base_lines = line_cnt;
			end
			if (op_q[i] == "I") begin
				run_inval(adr_q[i]);
			end else begin
				run_fetch(adr_q[i], flt_q[i], bok_q[i], l2_q[i]);
			end
		end
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule
